//--- logic/pagerank_pkg.sv
// ----------------------------------------------------------
// Shared types and constants for the PageRank scheduler.
// Imported by every RTL module and by the testbench.
// ----------------------------------------------------------
`default_nettype none

package pagerank_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  localparam int WORD_BYTES = 4;

  // Host request message, 65 bits
  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t data;
  } host_req_t;

  // Host response message, 33 bits
  typedef struct packed {
    logic  write;
    word_t data;
  } host_resp_t;

  // ----------------------------------------------------------
  // Host register map
  // ----------------------------------------------------------
  localparam addr_t REG_START   = 32'd0;
  localparam addr_t REG_BASE_G  = 32'd1;
  localparam addr_t REG_BASE_R  = 32'd2;
  localparam addr_t REG_R_FIRST = 32'd8;
  localparam addr_t REG_G_FIRST = 32'd16;

  // Controller states
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    RESP    = 3'd1,
    FETCH_R = 3'd2,
    FETCH_G = 3'd3,
    DONE    = 3'd4
  } sched_state_t;

endpackage

`default_nettype wire

//--- logic/pagerank_sched.sv
// ----------------------------------------------------------
// PageRank scheduler front end. Connects the controller,
// the paired fetcher and the R and G column buffers.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pagerank_sched
  import pagerank_pkg::*;
#(
  parameter int n_elems = 8
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire host_req_t host_req,
  input  wire logic host_req_val,
  output logic host_req_rdy,
  output host_resp_t host_resp,
  output logic host_resp_val,
  input  wire logic host_resp_rdy,
  output addr_t mem_req0_addr,
  output logic mem_req0_val,
  input  wire logic mem_req0_rdy,
  input  wire word_t mem_resp0_data,
  input  wire logic mem_resp0_val,
  output logic mem_resp0_rdy,
  output addr_t mem_req1_addr,
  output logic mem_req1_val,
  input  wire logic mem_req1_rdy,
  input  wire word_t mem_resp1_data,
  input  wire logic mem_resp1_val,
  output logic mem_resp1_rdy
);

  localparam int idx_w  = $clog2(n_elems);
  localparam int pair_w = (n_elems > 2) ? $clog2(n_elems / 2) : 1;

  logic              fetch_start;
  addr_t             fetch_base;
  addr_t             fetch_stride;
  logic              fetch_sel;
  logic              fetch_done;
  logic              wr_en;
  logic [pair_w-1:0] wr_pair;
  word_t [1:0]       wr_data;
  logic [idx_w-1:0]  rd_index;
  word_t             rank_rd_data;
  word_t             col_rd_data;
  logic              rank_wr_en;
  logic              col_wr_en;

  // Fetcher writes go to R during FETCH_R, to G during FETCH_G
  assign rank_wr_en = wr_en & ~fetch_sel;
  assign col_wr_en  = wr_en & fetch_sel;

  sched_ctrl #(.n_elems(n_elems)) u_sched_ctrl (
    .clk, .reset,
    .host_req, .host_req_val, .host_req_rdy,
    .host_resp, .host_resp_val, .host_resp_rdy,
    .fetch_start, .fetch_base, .fetch_stride, .fetch_sel, .fetch_done,
    .rd_index, .rank_rd_data, .col_rd_data
  );

  pair_fetch #(.n_elems(n_elems)) u_pair_fetch (
    .clk, .reset,
    .fetch_start, .fetch_base, .fetch_stride, .fetch_done,
    .mem_req0_addr, .mem_req0_val, .mem_req0_rdy,
    .mem_resp0_data, .mem_resp0_val, .mem_resp0_rdy,
    .mem_req1_addr, .mem_req1_val, .mem_req1_rdy,
    .mem_resp1_data, .mem_resp1_val, .mem_resp1_rdy,
    .wr_en, .wr_pair, .wr_data
  );

  vector_buffer #(.n_elems(n_elems)) u_rank_buf (
    .clk, .reset,
    .wr_en(rank_wr_en), .wr_pair, .wr_data,
    .rd_index, .rd_data(rank_rd_data)
  );

  vector_buffer #(.n_elems(n_elems)) u_col_buf (
    .clk, .reset,
    .wr_en(col_wr_en), .wr_pair, .wr_data,
    .rd_index, .rd_data(col_rd_data)
  );

endmodule

`default_nettype wire

//--- logic/pair_fetch.sv
// ----------------------------------------------------------
// Strided vector fetch over two memory read ports. Even
// elements go to port 0, odd ones to port 1, one pair at a time.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pair_fetch
  import pagerank_pkg::*;
#(
  parameter int n_elems = 8
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic fetch_start,
  input  wire addr_t fetch_base,
  input  wire addr_t fetch_stride,
  output logic fetch_done,
  output addr_t mem_req0_addr,
  output logic mem_req0_val,
  input  wire logic mem_req0_rdy,
  input  wire word_t mem_resp0_data,
  input  wire logic mem_resp0_val,
  output logic mem_resp0_rdy,
  output addr_t mem_req1_addr,
  output logic mem_req1_val,
  input  wire logic mem_req1_rdy,
  input  wire word_t mem_resp1_data,
  input  wire logic mem_resp1_val,
  output logic mem_resp1_rdy,
  output logic wr_en,
  output logic [((n_elems > 2) ? $clog2(n_elems / 2) : 1)-1:0] wr_pair,
  output word_t [1:0] wr_data
);

  localparam int pair_w = (n_elems > 2) ? $clog2(n_elems / 2) : 1;
  localparam logic [pair_w-1:0] last_pair = pair_w'(n_elems / 2 - 1);

  logic              active;
  logic [pair_w-1:0] pair;
  logic [1:0]        sent;
  logic [1:0]        held;
  logic [1:0]        req_go;
  logic [1:0]        resp_go;
  addr_t             addr_q [2];
  addr_t             step_q;
  word_t             data_q [2];

  assign mem_req0_val  = active & ~sent[0];
  assign mem_req1_val  = active & ~sent[1];
  assign mem_resp0_rdy = active & sent[0] & ~held[0];
  assign mem_resp1_rdy = active & sent[1] & ~held[1];
  assign mem_req0_addr = addr_q[0];
  assign mem_req1_addr = addr_q[1];

  assign req_go  = {mem_req1_val & mem_req1_rdy, mem_req0_val & mem_req0_rdy};
  assign resp_go = {mem_resp1_val & mem_resp1_rdy, mem_resp0_val & mem_resp0_rdy};

  // Pair is complete once both words are in hand
  assign wr_en   = active & (&held);
  assign wr_pair = pair;
  assign wr_data = {data_q[1], data_q[0]};

  // ----------------------------------------------------------
  // Per-pair control
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      active     <= 1'b0;
      pair       <= '0;
      sent       <= '0;
      held       <= '0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      if (fetch_start) begin
        active <= 1'b1;
        pair   <= '0;
        sent   <= '0;
        held   <= '0;
      end else if (wr_en) begin
        sent <= '0;
        held <= '0;
        pair <= pair + 1'b1;
        if (pair == last_pair) begin
          active     <= 1'b0;
          fetch_done <= 1'b1;
        end
      end else begin
        sent <= sent | req_go;
        held <= held | resp_go;
      end
    end
  end

  // Running addresses advance by two strides per pair
  always_ff @(posedge clk) begin
    if (fetch_start) begin
      addr_q[0] <= fetch_base;
      addr_q[1] <= fetch_base + fetch_stride;
      step_q    <= fetch_stride << 1;
    end else if (wr_en) begin
      addr_q[0] <= addr_q[0] + step_q;
      addr_q[1] <= addr_q[1] + step_q;
    end
    if (resp_go[0]) begin
      data_q[0] <= mem_resp0_data;
    end
    if (resp_go[1]) begin
      data_q[1] <= mem_resp1_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/sched_ctrl.sv
// ----------------------------------------------------------
// Host-facing controller: register decode, config state,
// fetch sequencing for R then one G column, and readback.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sched_ctrl
  import pagerank_pkg::*;
#(
  parameter int n_elems = 8
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire host_req_t host_req,
  input  wire logic host_req_val,
  output logic host_req_rdy,
  output host_resp_t host_resp,
  output logic host_resp_val,
  input  wire logic host_resp_rdy,
  output logic fetch_start,
  output addr_t fetch_base,
  output addr_t fetch_stride,
  output logic fetch_sel,
  input  wire logic fetch_done,
  output logic [$clog2(n_elems)-1:0] rd_index,
  input  wire word_t rank_rd_data,
  input  wire word_t col_rd_data
);

  localparam int idx_w = $clog2(n_elems);

  sched_state_t     state;
  sched_state_t     state_next;
  word_t            base_g;
  word_t            base_r;
  logic [idx_w-1:0] col;
  logic             req_go;
  logic             resp_go;
  logic             is_start;
  logic             in_r;
  logic             in_g;
  word_t            rd_word;

  assign req_go   = host_req_val & host_req_rdy;
  assign resp_go  = host_resp_val & host_resp_rdy;
  assign is_start = host_req.write && (host_req.addr == REG_START);

  // Handshake outputs come straight from the state
  assign host_req_rdy  = (state == IDLE);
  assign host_resp_val = (state == RESP) || (state == DONE);

  // ----------------------------------------------------------
  // Readback decode
  // ----------------------------------------------------------
  assign in_r = (host_req.addr >= REG_R_FIRST) && (host_req.addr < REG_R_FIRST + n_elems);
  assign in_g = (host_req.addr >= REG_G_FIRST) && (host_req.addr < REG_G_FIRST + n_elems);

  // Both readback windows are 8-word aligned, so the low address bits index either buffer
  assign rd_index = idx_w'(host_req.addr);

  always_comb begin
    if (host_req.addr == REG_BASE_G) begin
      rd_word = base_g;
    end else if (host_req.addr == REG_BASE_R) begin
      rd_word = base_r;
    end else if (in_r) begin
      rd_word = rank_rd_data;
    end else if (in_g) begin
      rd_word = col_rd_data;
    end else begin
      rd_word = '0;
    end
  end

  // ----------------------------------------------------------
  // Scheduling FSM
  // ----------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_go) begin
          state_next = is_start ? FETCH_R : RESP;
        end
      end
      FETCH_R: begin
        if (fetch_done) begin
          state_next = FETCH_G;
        end
      end
      FETCH_G: begin
        if (fetch_done) begin
          state_next = DONE;
        end
      end
      RESP, DONE: begin
        if (resp_go) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      fetch_start <= 1'b0;
      base_g      <= '0;
      base_r      <= '0;
      col         <= '0;
    end else begin
      state <= state_next;
      // One pulse for R on accept, one for G after R completes
      fetch_start <= (req_go && is_start) || ((state == FETCH_R) && fetch_done);
      if (req_go && host_req.write) begin
        if (host_req.addr == REG_BASE_G) begin
          base_g <= host_req.data;
        end
        if (host_req.addr == REG_BASE_R) begin
          base_r <= host_req.data;
        end
        if (host_req.addr == REG_START) begin
          col <= idx_w'(host_req.data % n_elems);
        end
      end
    end
  end

  // Response captured at accept and held until taken
  always_ff @(posedge clk) begin
    if (req_go) begin
      host_resp.write <= host_req.write;
      host_resp.data  <= host_req.write ? '0 : rd_word;
    end
  end

  // Column c of row-major G starts at base_g + c words, one row apart
  assign fetch_sel    = (state == FETCH_G);
  assign fetch_base   = fetch_sel ? base_g + addr_t'(col) * WORD_BYTES : base_r;
  assign fetch_stride = fetch_sel ? addr_t'(n_elems * WORD_BYTES) : addr_t'(WORD_BYTES);

endmodule

`default_nettype wire

//--- logic/vector_buffer.sv
// ----------------------------------------------------------
// On-chip word buffer, written one even/odd pair per cycle
// and read one word at a time without latency.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vector_buffer
  import pagerank_pkg::*;
#(
  parameter int n_elems = 8
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic wr_en,
  input  wire logic [((n_elems > 2) ? $clog2(n_elems / 2) : 1)-1:0] wr_pair,
  input  wire word_t [1:0] wr_data,
  input  wire logic [$clog2(n_elems)-1:0] rd_index,
  output word_t rd_data
);

  word_t mem [n_elems];

  // Pair k lands in words 2k and 2k+1
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < n_elems; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[2 * int'(wr_pair)]     <= wr_data[0];
      mem[2 * int'(wr_pair) + 1] <= wr_data[1];
    end
  end

  // Out-of-range index reads as zero when n_elems is not a power of two
  always_comb begin
    if (int'(rd_index) < n_elems) begin
      rd_data = mem[rd_index];
    end else begin
      rd_data = '0;
    end
  end

endmodule

`default_nettype wire

//--- pagerank_sched.f
logic/pagerank_pkg.sv
logic/vector_buffer.sv
logic/pair_fetch.sv
logic/sched_ctrl.sv
logic/pagerank_sched.sv
testbench/pagerank_sched_props.sv
testbench/tb_pagerank_sched.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PageRank scheduler testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pagerank_sched -f pagerank_sched.f -o sim_pagerank_sched

# The simulator exits non-zero on a failure; the log decides the result
./obj_dir/sim_pagerank_sched +verilator+error+limit+100 | tee sim.log || true

if grep -q "^TEST PASS$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- testbench/pagerank_sched_props.sv
// ----------------------------------------------------------
// Handshake assertions, bound into every pagerank_sched.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pagerank_sched_props
  import pagerank_pkg::*;
(
  input wire logic       clk,
  input wire logic       reset,
  input wire logic       host_req_rdy,
  input wire host_resp_t host_resp,
  input wire logic       host_resp_val,
  input wire logic       host_resp_rdy,
  input wire addr_t      mem_req0_addr,
  input wire logic       mem_req0_val,
  input wire logic       mem_req0_rdy,
  input wire addr_t      mem_req1_addr,
  input wire logic       mem_req1_val,
  input wire logic       mem_req1_rdy
);

  // Read by the testbench to turn a firing assertion into a failed run
  int assert_fails = 0;

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
      host_resp_val && !host_resp_rdy |=> host_resp_val && $stable(host_resp))
    else begin
      assert_fails = assert_fails + 1;
      $error("host response dropped or changed before it was taken");
    end

  a_req0_hold: assert property (@(posedge clk) disable iff (reset)
      mem_req0_val && !mem_req0_rdy |=> mem_req0_val && $stable(mem_req0_addr))
    else begin
      assert_fails = assert_fails + 1;
      $error("memory port 0 request dropped or changed before acceptance");
    end

  a_req1_hold: assert property (@(posedge clk) disable iff (reset)
      mem_req1_val && !mem_req1_rdy |=> mem_req1_val && $stable(mem_req1_addr))
    else begin
      assert_fails = assert_fails + 1;
      $error("memory port 1 request dropped or changed before acceptance");
    end

  a_rdy_excl: assert property (@(posedge clk) disable iff (reset)
      !(host_req_rdy && host_resp_val))
    else begin
      assert_fails = assert_fails + 1;
      $error("host request ready while a response is pending");
    end

endmodule

bind pagerank_sched pagerank_sched_props u_props (
  .clk(clk), .reset(reset), .host_req_rdy(host_req_rdy),
  .host_resp(host_resp), .host_resp_val(host_resp_val), .host_resp_rdy(host_resp_rdy),
  .mem_req0_addr(mem_req0_addr), .mem_req0_val(mem_req0_val), .mem_req0_rdy(mem_req0_rdy),
  .mem_req1_addr(mem_req1_addr), .mem_req1_val(mem_req1_val), .mem_req1_rdy(mem_req1_rdy)
);

`default_nettype wire

//--- testbench/tb_pagerank_sched.sv
// ----------------------------------------------------------
// Testbench for the PageRank scheduler: host driver, two-port
// memory model with random stalls, reference model and checks.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_pagerank_sched
  import pagerank_pkg::*;
();

  localparam int    n_elems    = 8;
  localparam int    clk_period = 4;
  localparam int    max_stall  = 3;
  localparam addr_t base_r_val = 32'h0000_1000;
  localparam addr_t base_g_val = 32'h0000_2000;
  // Two rounds of 4 config reads, 2 unmapped reads and 2 starts with 16 readbacks
  localparam int num_reqs  = 2 * (4 + 2 + 2 * (1 + 2 * n_elems));
  localparam int num_pairs = 2 * 2 * 2 * (n_elems / 2);
  localparam int watchdog_cycles =
    2 * (num_reqs * (10 + max_stall) + num_pairs * (2 * max_stall + 6) + 20);

  logic       clk;
  logic       reset;
  host_req_t  host_req;
  logic       host_req_val;
  logic       host_req_rdy;
  host_resp_t host_resp;
  logic       host_resp_val;
  logic       host_resp_rdy;
  addr_t      req_addr [2];
  logic       req_val [2];
  logic       req_rdy [2];
  word_t      resp_data [2];
  logic       resp_val [2];
  logic       resp_rdy [2];

  // Memory model state, one in-order queue per port
  addr_t       pend [2][8];
  int          head [2];
  int          tail [2];
  int          req_stall [2];
  int          resp_stall [2];
  int          hits [logic [32:0]];
  bit          stalls;
  logic [31:0] lcg_state;
  int          fail_count;

  pagerank_sched #(.n_elems(n_elems)) u_pagerank_sched (
    .clk, .reset,
    .host_req, .host_req_val, .host_req_rdy,
    .host_resp, .host_resp_val, .host_resp_rdy,
    .mem_req0_addr(req_addr[0]), .mem_req0_val(req_val[0]), .mem_req0_rdy(req_rdy[0]),
    .mem_resp0_data(resp_data[0]), .mem_resp0_val(resp_val[0]),
    .mem_resp0_rdy(resp_rdy[0]),
    .mem_req1_addr(req_addr[1]), .mem_req1_val(req_val[1]), .mem_req1_rdy(req_rdy[1]),
    .mem_resp1_data(resp_data[1]), .mem_resp1_val(resp_val[1]),
    .mem_resp1_rdy(resp_rdy[1])
  );

  always #(clk_period / 2) clk = ~clk;

  // ----------------------------------------------------------
  // Reference model and helpers
  // ----------------------------------------------------------
  function automatic word_t mem_word(input addr_t a);
    return (a ^ 32'h5a5a_0000) + (a >> 2);
  endfunction

  // Address of element i of R, or of element (i, col) of row-major G
  function automatic addr_t elem_addr(input bit is_g, input int col, input int i);
    if (is_g) begin
      return base_g_val + addr_t'(col * WORD_BYTES) + addr_t'(i * n_elems * WORD_BYTES);
    end
    return base_r_val + addr_t'(i * WORD_BYTES);
  endfunction

  function automatic int next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[30:16]);
  endfunction

  function automatic int draw_stall();
    if (!stalls) begin
      return 0;
    end
    return next_rand() % (max_stall + 1);
  endfunction

  task automatic check(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      fail_count++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  task automatic check_quiet(input string when_s);
    check({when_s, " host_resp_val"}, 0, host_resp_val);
    check({when_s, " host_req_rdy"}, 1, host_req_rdy);
    for (int p = 0; p < 2; p++) begin
      check($sformatf("%s mem_req%0d_val", when_s, p), 0, req_val[p]);
      check($sformatf("%s mem_resp%0d_rdy", when_s, p), 0, resp_rdy[p]);
    end
  endtask

  // ----------------------------------------------------------
  // Host driver
  // ----------------------------------------------------------
  task automatic host_xfer(input logic wr, input addr_t a, input word_t d,
                           output host_resp_t resp);
    int wait_cycles;
    host_req     = '{write: wr, addr: a, data: d};
    host_req_val = 1'b1;
    do @(negedge clk); while (!host_req_rdy);
    @(posedge clk);
    #1;
    host_req_val = 1'b0;
    wait_cycles  = draw_stall();
    while (1) begin
      host_resp_rdy = (wait_cycles == 0);
      @(negedge clk);
      if (host_resp_val && host_resp_rdy) break;
      @(posedge clk);
      #1;
      if (wait_cycles > 0) wait_cycles--;
    end
    resp = host_resp;
    @(posedge clk);
    #1;
    host_resp_rdy = 1'b0;
  endtask

  task automatic write_reg(input addr_t a, input word_t d);
    host_resp_t r;
    host_xfer(1'b1, a, d, r);
    check($sformatf("write %0d resp bit", a), 1, r.write);
    check($sformatf("write %0d resp data", a), 0, r.data);
  endtask

  task automatic read_expect(input string name, input addr_t a, input word_t exp);
    host_resp_t r;
    host_xfer(1'b0, a, '0, r);
    check({name, " resp bit"}, 0, r.write);
    check(name, exp, r.data);
  endtask

  // Each expected address seen once on its port, and nothing else
  task automatic check_fetch(input int col);
    logic [32:0] key;
    check("memory request count", 2 * n_elems, hits.num());
    for (int i = 0; i < n_elems; i++) begin
      key = {1'(i % 2), elem_addr(1'b0, 0, i)};
      check($sformatf("R[%0d] request", i), 1, hits.exists(key) ? hits[key] : 0);
      key = {1'(i % 2), elem_addr(1'b1, col, i)};
      check($sformatf("G[%0d] request", i), 1, hits.exists(key) ? hits[key] : 0);
    end
  endtask

  task automatic start_and_check(input word_t d);
    int col;
    col = int'(d % n_elems);
    hits.delete();
    write_reg(REG_START, d);
    check_fetch(col);
    for (int i = 0; i < n_elems; i++) begin
      read_expect($sformatf("R[%0d]", i), REG_R_FIRST + i, mem_word(elem_addr(1'b0, 0, i)));
      read_expect($sformatf("G[%0d]", i), REG_G_FIRST + i, mem_word(elem_addr(1'b1, col, i)));
    end
  endtask

  task automatic run_round(input bit with_stalls);
    stalls = with_stalls;
    write_reg(REG_BASE_G, base_g_val);
    write_reg(REG_BASE_R, base_r_val);
    read_expect("base_g", REG_BASE_G, base_g_val);
    read_expect("base_r", REG_BASE_R, base_r_val);
    read_expect("unmapped 5", 32'd5, '0);
    read_expect("unmapped 24", 32'd24, '0);
    start_and_check(32'd3);
    // Column index wraps modulo n_elems
    start_and_check(32'd11);
  endtask

  // ----------------------------------------------------------
  // Memory model, both ports in one process
  // ----------------------------------------------------------
  initial begin
    logic        take_req [2];
    logic        take_resp [2];
    addr_t       seen [2];
    logic [32:0] key;
    for (int p = 0; p < 2; p++) begin
      req_rdy[p]    = 1'b0;
      resp_val[p]   = 1'b0;
      resp_data[p]  = '0;
      head[p]       = 0;
      tail[p]       = 0;
      req_stall[p]  = 0;
      resp_stall[p] = 0;
    end
    forever begin
      @(negedge clk);
      for (int p = 0; p < 2; p++) begin
        take_req[p]  = req_val[p] && req_rdy[p];
        take_resp[p] = resp_val[p] && resp_rdy[p];
        seen[p]      = req_addr[p];
      end
      @(posedge clk);
      #1;
      for (int p = 0; p < 2; p++) begin
        if (take_req[p]) begin
          pend[p][tail[p] % 8] = seen[p];
          tail[p]++;
          key = {1'(p), seen[p]};
          hits[key] = hits.exists(key) ? hits[key] + 1 : 1;
          req_stall[p] = draw_stall();
        end else if (req_stall[p] > 0) begin
          req_stall[p]--;
        end
        // A presented response stays until taken, so its stall only restarts on take
        if (take_resp[p]) begin
          head[p]++;
          resp_stall[p] = draw_stall();
        end else if (resp_stall[p] > 0) begin
          resp_stall[p]--;
        end
        req_rdy[p]  = (req_stall[p] == 0) && (tail[p] - head[p] < 8);
        resp_val[p] = (resp_stall[p] == 0) && (tail[p] != head[p]);
        resp_data[p] = resp_val[p] ? mem_word(pend[p][head[p] % 8]) : '0;
      end
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    host_req      = '0;
    host_req_val  = 1'b0;
    host_resp_rdy = 1'b0;
    stalls        = 1'b0;
    lcg_state     = 32'ha84c_c038;
    fail_count    = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_quiet("during reset");
    @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_quiet("after reset");
    @(posedge clk);
    #1;
    run_round(1'b0);
    run_round(1'b1);
    if (fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Bound assertions count their failures
  always @(negedge clk) begin
    if (u_pagerank_sched.u_props.assert_fails != 0) begin
      $display("TEST FAIL");
      $fatal(1, "A handshake assertion in the DUT fired");
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("TEST FAIL");
    $fatal(1, "Watchdog expired, the DUT stopped making progress");
  end

endmodule

`default_nettype wire
